/* emailbox.f */
hw/emailbox_pkg.sv
hw/mailbox_push_if.sv
hw/emesh_write_decode.sv
hw/mailbox_fifo_async.sv
hw/mailbox_read_port.sv
hw/emailbox.sv
verif/emailbox_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = emailbox_tb
FILELIST  = emailbox.f
OBJ_DIR   = obj_dir
PASS_MSG  = Testbench passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* verif/emailbox_tb.sv */
////////////////////
// mailbox testbench
// two clocks, mesh packet stimulus, mi reads
// queue model of the mailbox and mi_dout checker
////////////////////

`timescale 1ns/10ps

module emailbox_tb;
   import emailbox_pkg::*;

   localparam logic [11:0] NODE_ID = 12'h3A5;
   localparam int          TIMEOUT = 200;   // rd_clk cycles per wait

   logic     nreset;
   logic     wr_clk;
   logic     rd_clk;
   logic     emesh_access;
   packet_t  emesh_packet;
   logic     mi_en;
   logic     mi_we;
   mi_addr_t mi_addr;
   entry_t   mi_din;
   entry_t   mi_dout;
   logic     mailbox_full;
   logic     mailbox_not_empty;

   integer   seed = 32'h441bfe74;
   entry_t   model_q [$];   // expected mailbox contents, oldest first
   entry_t   exp_val;       // mi_dout due after the current bus cycle
   string    exp_name;
   logic     chk_en;
   entry_t   chk_val;
   string    chk_name;
   int       n_checks;

   emailbox #(.ID(NODE_ID)) UUT (
      .nreset            (nreset),
      .wr_clk            (wr_clk),
      .rd_clk            (rd_clk),
      .emesh_access      (emesh_access),
      .emesh_packet      (emesh_packet),
      .mi_en             (mi_en),
      .mi_we             (mi_we),
      .mi_addr           (mi_addr),
      .mi_din            (mi_din),
      .mi_dout           (mi_dout),
      .mailbox_full      (mailbox_full),
      .mailbox_not_empty (mailbox_not_empty)
   );

   always #2 rd_clk = ~rd_clk;   // 4 ns
   always #3 wr_clk = ~wr_clk;   // 6 ns, starts high so its edges miss rd_clk + 1

   task automatic stop_on_error(input string why);
      $display("%s", why);
      $display("Testbench failed");
      $fatal(1, "stopped at first error");
   endtask

   // packet with the destination built from id, group and register index
   function automatic packet_t build_packet(input logic [11:0] id, input logic [3:0] group,
                                            input logic [RFAW-1:0] idx, input logic write,
                                            input word_t data, input addr_t src);
      addr_t dst;
      dst = {id, group, 8'h00, idx, 2'b00};
      return {src, data, dst, 4'h0, 2'b10, 1'b0, write};   // datamode word
   endfunction

   // mi_dout for a bus cycle, from the model front
   function automatic entry_t expected_read(input logic we, input logic [RFAW-1:0] idx);
      entry_t front;
      front = (model_q.size() != 0) ? model_q[0] : '0;
      if (we)
         return '0;             // writes read back nothing
      else if (idx == E_MAILBOXLO)
         return front;
      else if (idx == E_MAILBOXHI)
         return {front[63:32], front[63:32]};
      else
         return '0;
   endfunction

   // compares mi_dout one rd_clk cycle after each bus cycle
   always @(posedge rd_clk)
   begin
      if (chk_en)
      begin
         chk_val  = exp_val;    // taken at the decode edge
         chk_name = exp_name;
         #1;
         n_checks++;
         assert (mi_dout === chk_val)
         else stop_on_error($sformatf("mismatch %s: expected %h, actual %h",
                                      chk_name, chk_val, mi_dout));
      end
   end

   task automatic check_level(input string name, input logic exp, input logic act);
      assert (act === exp)
      else stop_on_error($sformatf("mismatch %s: expected %0b, actual %0b", name, exp, act));
   endtask

   // wr_clk side stimulus
   task automatic send_packet(input logic access, input packet_t pkt, input logic hit);
      @(posedge wr_clk);
      #1;
      emesh_access = access;
      emesh_packet = pkt;
      if (hit)
      begin
         model_q.push_back({pkt[103:72], pkt[71:40]});   // srcaddr high, data low
      end
   endtask

   task automatic send_random_entry();
      word_t d;
      addr_t s;
      d = $random(seed);
      s = $random(seed);
      send_packet(1'b1, build_packet(NODE_ID, EGROUP_MMR, E_MAILBOXLO, 1'b1, d, s), 1'b1);
   endtask

   task automatic send_miss(input logic access, input logic [11:0] id, input logic [3:0] group,
                            input logic [RFAW-1:0] idx, input logic write);
      word_t d;
      addr_t s;
      d = $random(seed);
      s = $random(seed);
      send_packet(access, build_packet(id, group, idx, write, d, s), 1'b0);
   endtask

   task automatic wr_idle();
      @(posedge wr_clk);
      #1;
      emesh_access = 1'b0;
   endtask

   // rd_clk side, one bus cycle plus one idle cycle
   task automatic mi_access(input logic we, input logic [RFAW-1:0] idx, input string name);
      mi_en    = 1'b1;
      mi_we    = we;
      mi_addr  = {idx, 2'b00};
      exp_val  = expected_read(we, idx);
      exp_name = name;
      if (!we && idx == E_MAILBOXHI && model_q.size() != 0)
      begin
         void'(model_q.pop_front());   // hi read pops
      end
      @(posedge rd_clk);
      #1;
      mi_en    = 1'b0;
      mi_we    = 1'b0;
      exp_val  = '0;
      exp_name = "idle";
      @(posedge rd_clk);
      #1;
   endtask

   task automatic wait_not_empty(input logic want, input string name);
      int n;
      n = 0;
      @(posedge rd_clk);
      #1;
      while (mailbox_not_empty !== want && n < TIMEOUT)
      begin
         @(posedge rd_clk);
         #1;
         n++;
      end
      if (mailbox_not_empty !== want)
         stop_on_error($sformatf("%s: mailbox_not_empty never went to %0b", name, want));
   endtask

   task automatic wait_full(input logic want, input string name);
      int n;
      n = 0;
      @(posedge rd_clk);
      #1;
      while (mailbox_full !== want && n < TIMEOUT)
      begin
         @(posedge rd_clk);
         #1;
         n++;
      end
      if (mailbox_full !== want)
         stop_on_error($sformatf("%s: mailbox_full never went to %0b", name, want));
   endtask

   task automatic read_entry(input string name);
      wait_not_empty(1'b1, name);
      mi_access(1'b0, E_MAILBOXLO, {name, " lo"});
      mi_access(1'b0, E_MAILBOXHI, {name, " hi"});
   endtask

   initial
   begin
      rd_clk       = 1'b0;
      wr_clk       = 1'b1;
      nreset       = 1'b0;
      emesh_access = 1'b0;
      emesh_packet = '0;
      mi_en        = 1'b0;
      mi_we        = 1'b0;
      mi_addr      = '0;
      mi_din       = '0;
      exp_val      = '0;
      exp_name     = "idle";
      chk_en       = 1'b0;
      n_checks     = 0;
      repeat (5) @(posedge rd_clk);
      #1;
      nreset = 1'b1;

      // levels and read data out of reset
      check_level("reset not_empty", 1'b0, mailbox_not_empty);
      check_level("reset full", 1'b0, mailbox_full);
      assert (mi_dout === '0)
      else stop_on_error($sformatf("mismatch reset mi_dout: expected %h, actual %h",
                                   64'h0, mi_dout));
      chk_en = 1'b1;

      // random hits come out in order
      repeat (12) send_random_entry();
      wr_idle();
      while (model_q.size() != 0) read_entry("in order");
      check_level("drained not_empty", 1'b0, mailbox_not_empty);

      // misses, then one hit as a marker
      send_miss(1'b1, 12'h3A4, EGROUP_MMR, E_MAILBOXLO, 1'b1);   // wrong id
      send_miss(1'b1, NODE_ID, 4'hE, E_MAILBOXLO, 1'b1);         // wrong group
      send_miss(1'b1, NODE_ID, EGROUP_MMR, E_MAILBOXHI, 1'b1);   // wrong reg
      send_miss(1'b1, NODE_ID, EGROUP_MMR, E_MAILBOXLO, 1'b0);   // read packet
      send_miss(1'b0, NODE_ID, EGROUP_MMR, E_MAILBOXLO, 1'b1);   // no access
      send_random_entry();
      wr_idle();
      read_entry("miss filter");
      check_level("miss filter not_empty", 1'b0, mailbox_not_empty);

      // lo reads and other bus cycles leave the entry in place
      send_random_entry();
      wr_idle();
      wait_not_empty(1'b1, "lo repeat");
      mi_access(1'b0, E_MAILBOXLO, "lo repeat 1");
      mi_access(1'b0, E_MAILBOXLO, "lo repeat 2");
      mi_access(1'b0, E_MAILBOXLO, "lo repeat 3");
      mi_access(1'b0, 6'h05, "other index");
      mi_access(1'b1, E_MAILBOXHI, "mi write hi");
      mi_access(1'b1, E_MAILBOXLO, "mi write lo");
      check_level("no pop not_empty", 1'b1, mailbox_not_empty);
      mi_access(1'b0, E_MAILBOXLO, "lo after writes");
      mi_access(1'b0, E_MAILBOXHI, "single hi pop");
      check_level("single pop not_empty", 1'b0, mailbox_not_empty);

      // fill to full, free one slot, drain
      repeat (MBOX_DEPTH) send_random_entry();
      wr_idle();
      wait_full(1'b1, "fill");
      wait_not_empty(1'b1, "fill");
      mi_access(1'b0, E_MAILBOXHI, "full hi pop");
      wait_full(1'b0, "full release");
      while (model_q.size() != 0) read_entry("full drain");
      check_level("full drain not_empty", 1'b0, mailbox_not_empty);
      check_level("full drain full", 1'b0, mailbox_full);

      $display("mi_dout checks: %0d", n_checks);
      $display("Testbench passed");
      $finish;
   end

endmodule

/* hw/emailbox.sv */
////////////////////
// mesh mailbox top level
// write decode, async fifo, mi read port
////////////////////

`timescale 1ns/10ps

module emailbox #(
   parameter logic [11:0] ID = emailbox_pkg::DEFAULT_ID   // node id
) (
   input  logic                   nreset,              // async, active low
   input  logic                   wr_clk,              // mesh side
   input  logic                   rd_clk,              // host side
   input  logic                   emesh_access,
   input  emailbox_pkg::packet_t  emesh_packet,
   input  logic                   mi_en,
   input  logic                   mi_we,
   input  emailbox_pkg::mi_addr_t mi_addr,
   input  emailbox_pkg::entry_t   mi_din,              // no mi writes
   output emailbox_pkg::entry_t   mi_dout,
   output logic                   mailbox_full,
   output logic                   mailbox_not_empty    // level interrupt
);
   import emailbox_pkg::*;

   entry_t fifo_data;    // oldest entry, show-ahead
   logic   fifo_empty;
   logic   fifo_pop;     // hi read

   mailbox_push_if push_if ();

   emesh_write_decode #(.ID(ID)) u_decode (
      .wr_clk       (wr_clk),
      .nreset       (nreset),
      .emesh_access (emesh_access),
      .emesh_packet (emesh_packet),
      .push_if      (push_if.decode_mp)
   );

   mailbox_fifo_async u_fifo (
      .wr_clk  (wr_clk),
      .rd_clk  (rd_clk),
      .nreset  (nreset),
      .push_if (push_if.fifo_mp),
      .pop     (fifo_pop),
      .rd_data (fifo_data),
      .empty   (fifo_empty)
   );

   mailbox_read_port u_read (
      .rd_clk  (rd_clk),
      .nreset  (nreset),
      .mi_en   (mi_en),
      .mi_we   (mi_we),
      .mi_addr (mi_addr),
      .rd_data (fifo_data),
      .empty   (fifo_empty),
      .pop     (fifo_pop),
      .mi_dout (mi_dout)
   );

   assign mailbox_not_empty = ~fifo_empty;
   assign mailbox_full      = push_if.full;   // wr_clk domain flag

endmodule

/* hw/mailbox_read_port.sv */
////////////////////
// mi read port
// lo read returns the entry, hi read the upper word twice
// hi read pops the fifo
////////////////////

`timescale 1ns/10ps

module mailbox_read_port (
   input  logic                   rd_clk,
   input  logic                   nreset,
   input  logic                   mi_en,
   input  logic                   mi_we,
   input  emailbox_pkg::mi_addr_t mi_addr,
   input  emailbox_pkg::entry_t   rd_data,
   input  logic                   empty,
   output logic                   pop,
   output emailbox_pkg::entry_t   mi_dout
);
   import emailbox_pkg::*;

   logic mi_rd;     // read cycle on the bus
   logic rd_lo;     // read of E_MAILBOXLO
   logic rd_hi;     // read of E_MAILBOXHI
   word_t hi_word;  // srcaddr half of the entry

   assign mi_rd = mi_en & ~mi_we;   // writes are ignored

   assign rd_lo = mi_rd & (mi_addr[RFAW+1:2] == E_MAILBOXLO);
   assign rd_hi = mi_rd & (mi_addr[RFAW+1:2] == E_MAILBOXHI);

   assign hi_word = rd_data[63:32];

   // hi read on an empty mailbox just returns a stale word
   assign pop = rd_hi & ~empty;

   // read data captured at decode, before the pop moves the pointer
   always_ff @(posedge rd_clk or negedge nreset)
   begin
      if (!nreset)
      begin
         mi_dout <= '0;
      end
      else if (rd_hi)
      begin
         mi_dout <= {hi_word, hi_word};   // high word in both halves
      end
      else if (rd_lo)
      begin
         mi_dout <= rd_data;              // whole entry
      end
      else
      begin
         mi_dout <= '0;                   // idle, writes, other regs
      end
   end

endmodule

/* hw/mailbox_fifo_async.sv */
////////////////////
// dual clock mailbox fifo
// gray pointers with two flop synchronizers
// full in wr_clk, empty in rd_clk
// show-ahead read data
////////////////////

`timescale 1ns/10ps

module mailbox_fifo_async (
   input  logic                                wr_clk,
   input  logic                                rd_clk,
   input  logic                                nreset,
   mailbox_push_if.fifo_mp                     push_if,
   input  logic                                pop,
   output emailbox_pkg::entry_t                rd_data,
   output logic                                empty
);
   import emailbox_pkg::*;

   entry_t mem [MBOX_DEPTH];   // storage, no reset

   // write domain pointers
   logic [MBOX_PTR_W-1:0] wr_bin;
   logic [MBOX_PTR_W-1:0] wr_gray;
   logic [MBOX_PTR_W-1:0] rd_gray_s1;   // rd pointer, first sync flop
   logic [MBOX_PTR_W-1:0] rd_gray_s2;   // rd pointer as seen in wr_clk

   // read domain pointers
   logic [MBOX_PTR_W-1:0] rd_bin;
   logic [MBOX_PTR_W-1:0] rd_gray;
   logic [MBOX_PTR_W-1:0] wr_gray_s1;   // wr pointer, first sync flop
   logic [MBOX_PTR_W-1:0] wr_gray_s2;   // wr pointer as seen in rd_clk

   logic [MBOX_PTR_W-1:0] wr_bin_nxt;
   logic [MBOX_PTR_W-1:0] rd_bin_nxt;

   function automatic logic [MBOX_PTR_W-1:0] bin2gray(
      input logic [MBOX_PTR_W-1:0] bin
   );
      return bin ^ (bin >> 1);
   endfunction

   // write side
   // every push writes, overflow is left to the system
   assign wr_bin_nxt = wr_bin + {{(MBOX_PTR_W-1){1'b0}}, push_if.push};

   always_ff @(posedge wr_clk)
   begin
      if (push_if.push)
      begin
         mem[wr_bin[MBOX_PTR_W-2:0]] <= {push_if.data_hi, push_if.data_lo};
      end
   end

   always_ff @(posedge wr_clk or negedge nreset)
   begin
      if (!nreset)
      begin
         wr_bin  <= '0;
         wr_gray <= '0;
      end
      else
      begin
         wr_bin  <= wr_bin_nxt;
         wr_gray <= bin2gray(wr_bin_nxt);
      end
   end

   // rd pointer into wr_clk
   always_ff @(posedge wr_clk or negedge nreset)
   begin
      if (!nreset)
      begin
         rd_gray_s1 <= '0;
         rd_gray_s2 <= '0;
      end
      else
      begin
         rd_gray_s1 <= rd_gray;
         rd_gray_s2 <= rd_gray_s1;
      end
   end

   // full when the pointers differ only in the two top gray bits
   // rises right after the edge that fills the last slot
   assign push_if.full = (wr_gray == {~rd_gray_s2[MBOX_PTR_W-1:MBOX_PTR_W-2],
                                      rd_gray_s2[MBOX_PTR_W-3:0]});

   // read side
   assign rd_bin_nxt = rd_bin + {{(MBOX_PTR_W-1){1'b0}}, pop};

   always_ff @(posedge rd_clk or negedge nreset)
   begin
      if (!nreset)
      begin
         rd_bin  <= '0;
         rd_gray <= '0;
      end
      else
      begin
         rd_bin  <= rd_bin_nxt;
         rd_gray <= bin2gray(rd_bin_nxt);
      end
   end

   // wr pointer into rd_clk
   always_ff @(posedge rd_clk or negedge nreset)
   begin
      if (!nreset)
      begin
         wr_gray_s1 <= '0;
         wr_gray_s2 <= '0;
      end
      else
      begin
         wr_gray_s1 <= wr_gray;
         wr_gray_s2 <= wr_gray_s1;
      end
   end

   assign empty = (rd_gray == wr_gray_s2);   // pessimistic, clears after sync

   // oldest entry always on the output
   assign rd_data = mem[rd_bin[MBOX_PTR_W-2:0]];

   // pop on an empty fifo would walk the rd pointer past the wr pointer
   a_no_pop_when_empty : assert property (
      @(posedge rd_clk) disable iff (!nreset)
      pop |-> !empty
   ) else $error("mailbox pop while fifo empty");

   // push into a full fifo overwrites the oldest unread entry
   a_no_write_when_full : assert property (
      @(posedge wr_clk) disable iff (!nreset)
      push_if.push |-> !push_if.full
   ) else $error("mailbox write into full fifo");

endmodule

/* hw/emesh_write_decode.sv */
////////////////////
// mesh write decode
// picks out writes to this node's mailbox register
// and registers a push with the entry
////////////////////

`timescale 1ns/10ps

module emesh_write_decode #(
   parameter logic [11:0] ID = emailbox_pkg::DEFAULT_ID   // node id
) (
   input  logic                  wr_clk,
   input  logic                  nreset,
   input  logic                  emesh_access,
   input  emailbox_pkg::packet_t emesh_packet,
   mailbox_push_if.decode_mp     push_if
);
   import emailbox_pkg::*;

   logic  pkt_write;     // write flag
   addr_t pkt_dstaddr;   // where the write goes
   word_t pkt_data;      // payload word
   addr_t pkt_srcaddr;   // sender, kept as high word
   logic  id_hit;
   logic  group_hit;
   logic  reg_hit;
   logic  mbox_hit;      // packet goes into the mailbox

   // packet fields, datamode and ctrlmode do not matter here
   assign pkt_write   = emesh_packet[0];
   assign pkt_dstaddr = emesh_packet[39:8];
   assign pkt_data    = emesh_packet[71:40];
   assign pkt_srcaddr = emesh_packet[103:72];

   // address decode
   assign id_hit    = (pkt_dstaddr[31:20] == ID);
   assign group_hit = (pkt_dstaddr[19:16] == EGROUP_MMR);
   assign reg_hit   = (pkt_dstaddr[RFAW+1:2] == E_MAILBOXLO);   // lo index only

   assign mbox_hit = emesh_access & pkt_write & id_hit & group_hit & reg_hit;

   // push strobe, high for exactly the cycle after the hit
   always_ff @(posedge wr_clk or negedge nreset)
   begin
      if (!nreset)
      begin
         push_if.push <= 1'b0;
      end
      else
      begin
         push_if.push <= mbox_hit;
      end
   end

   // entry words follow the strobe
   always_ff @(posedge wr_clk)
   begin
      if (mbox_hit)
      begin
         push_if.data_lo <= pkt_data;
         push_if.data_hi <= pkt_srcaddr;
      end
   end

   // fifo full is seen here a cycle late, any push into it overflows
   a_no_push_when_full : assert property (
      @(posedge wr_clk) disable iff (!nreset)
      !(push_if.push && push_if.full)
   ) else $error("mailbox push while fifo full");

endmodule

/* hw/mailbox_push_if.sv */
////////////////////
// push path from write decode into the fifo
// wr_clk domain
////////////////////

`timescale 1ns/10ps

interface mailbox_push_if;
   import emailbox_pkg::*;

   logic  push;      // one entry per high cycle
   word_t data_lo;   // mesh data
   word_t data_hi;   // mesh source address
   logic  full;      // fifo status, no back-pressure

   // decode side
   modport decode_mp (
      output push,
      output data_lo,
      output data_hi,
      input  full
   );

   // fifo side
   modport fifo_mp (
      input  push,
      input  data_lo,
      input  data_hi,
      output full
   );

endinterface

/* hw/emailbox_pkg.sv */
////////////////////
// mailbox package
// mesh packet, address and data types
// mmr register map for the mailbox
// fifo depth and pointer width
////////////////////

package emailbox_pkg;

   // register file address width (word index bits)
   localparam int RFAW = 6;

   // mesh packet layout, lsb first
   //  [0]      write flag
   //  [3:2]    datamode
   //  [7:4]    ctrlmode
   //  [39:8]   destination address
   //  [71:40]  data
   //  [103:72] source address
   typedef logic [103:0] packet_t;

   typedef logic [31:0] addr_t;    // mesh address
   typedef logic [31:0] word_t;    // one data word

   // mailbox entry, srcaddr in the upper word, data in the lower
   typedef logic [63:0] entry_t;

   // byte address on the mi bus
   typedef logic [RFAW+1:0] mi_addr_t;

   // mmr group code, sits in address bits 19:16
   localparam logic [3:0] EGROUP_MMR = 4'hF;

   // mailbox register indices, address bits RFAW+1:2
   localparam logic [RFAW-1:0] E_MAILBOXLO = 6'h09;
   localparam logic [RFAW-1:0] E_MAILBOXHI = 6'h0A;

   // fifo size, depth must stay a power of two
   localparam int MBOX_DEPTH = 32;
   localparam int MBOX_PTR_W = $clog2(MBOX_DEPTH) + 1;   // extra wrap bit

   // node id when none is given, address bits 31:20
   localparam logic [11:0] DEFAULT_ID = 12'h000;

endpackage
